//--- hdl/gat_cfg.svh
`ifndef GAT_CFG_SVH
`define GAT_CFG_SVH

// Operand width of H values, weights and a entries
`define GAT_DATA_W 8

// Layer sizes
`define GAT_FEAT_IN 16
`define GAT_FEAT_OUT 4
`define GAT_TOTAL_NODES 8

// Sparse entry memory depth
`define GAT_H_DEPTH 64

// 16-bit product plus growth over 16 input features
`define GAT_WH_W 20

`define GAT_COEF_W 32

`define GAT_FIFO_DEPTH 8

`endif

//--- hdl/gat_pkg.sv
`include "gat_cfg.svh"

package gat_pkg;

  typedef logic signed [`GAT_DATA_W-1:0] data_t;
  typedef logic [$clog2(`GAT_FEAT_IN)-1:0] col_idx_t;
  // Value in the upper bits, column index below
  typedef logic [`GAT_DATA_W+$clog2(`GAT_FEAT_IN)-1:0] h_entry_t;
  typedef logic [$clog2(`GAT_H_DEPTH)-1:0] h_addr_t;
  typedef logic [$clog2(`GAT_TOTAL_NODES)-1:0] node_addr_t;
  typedef logic [$clog2(`GAT_FEAT_IN):0] row_len_t;
  typedef logic [$clog2(`GAT_TOTAL_NODES):0] num_node_t;
  // {row_len, num_node, first_flag}
  typedef logic [$bits(row_len_t)+$bits(num_node_t):0] node_info_t;
  typedef logic signed [`GAT_WH_W-1:0] wh_elem_t;
  // Element k at bits [k*GAT_WH_W +: GAT_WH_W]
  typedef logic [`GAT_FEAT_OUT*`GAT_WH_W-1:0] wh_vec_t;
  // {wh_vec, num_node, first_flag}
  typedef logic [$bits(wh_vec_t)+$bits(num_node_t):0] wh_word_t;
  typedef logic signed [`GAT_COEF_W-1:0] coef_t;
  typedef logic [$clog2(`GAT_FEAT_IN*`GAT_FEAT_OUT+2*`GAT_FEAT_OUT)-1:0] wgt_addr_t;

  typedef enum logic [2:0] {IDLE, INFO, ROW, DRAIN, WRITE} spmm_state_t;

endpackage

//--- hdl/gat_wgt_if.sv
`include "gat_cfg.svh"

interface gat_wgt_if;

  // Column of the sparse entry being accumulated
  gat_pkg::col_idx_t row_addr;
  // Weights of that column, one per output feature
  gat_pkg::data_t [`GAT_FEAT_OUT-1:0] row;
  // Source half first, destination half above it
  gat_pkg::data_t [2*`GAT_FEAT_OUT-1:0] a_vec;
  logic w_rdy;

  modport store (
    input  row_addr,
    output row,
    output a_vec,
    output w_rdy
  );

  modport spmm (
    output row_addr,
    input  row,
    input  w_rdy
  );

  modport dmvm (
    input  a_vec
  );

endinterface

//--- hdl/weight_store.sv
`include "gat_cfg.svh"

module weight_store (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wgt_wr_i,
  input  gat_pkg::wgt_addr_t wgt_addr_i,
  input  gat_pkg::data_t     wgt_data_i,
  input  logic               wgt_load_done_i,
  gat_wgt_if.store           wgt
);

  localparam int W_NUM = `GAT_FEAT_IN * `GAT_FEAT_OUT;
  localparam int A_NUM = 2 * `GAT_FEAT_OUT;
  localparam int W_AW  = $clog2(W_NUM);
  localparam int A_AW  = $clog2(A_NUM);
  localparam int O_AW  = $clog2(`GAT_FEAT_OUT);

  gat_pkg::data_t w_mem [W_NUM];
  gat_pkg::data_t a_mem [A_NUM];

  always_ff @(posedge clk) begin
    if (wgt_wr_i) begin
      if (wgt_addr_i < W_NUM) begin
        w_mem[wgt_addr_i[W_AW-1:0]] <= wgt_data_i;
      end else begin
        // a entries start at W_NUM, a multiple of A_NUM
        a_mem[wgt_addr_i[A_AW-1:0]] <= wgt_data_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wgt.w_rdy <= 1'b0;
    end else begin
      wgt.w_rdy <= wgt_load_done_i;
    end
  end

  // Row major, so a column's weights sit side by side
  always_comb begin
    for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
      wgt.row[k] = w_mem[{wgt.row_addr, O_AW'(k)}];
    end
    for (int j = 0; j < A_NUM; j++) begin
      wgt.a_vec[j] = a_mem[j];
    end
  end

  // Weights stay frozen while the compute side may be using them
  a_no_write_when_ready: assert property (
    @(posedge clk) disable iff (!rst_n) wgt.w_rdy |-> !wgt_wr_i
  ) else $error("weight write while w_rdy is high");

endmodule

//--- hdl/spmm_engine.sv
`include "gat_cfg.svh"

module spmm_engine (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  gat_wgt_if.spmm             wgt,
  output gat_pkg::node_addr_t node_info_addr_o,
  input  gat_pkg::node_info_t node_info_i,
  output gat_pkg::h_addr_t    h_data_addr_o,
  input  gat_pkg::h_entry_t   h_data_i,
  input  logic                afull_i,
  output logic                wh_ena_o,
  output gat_pkg::node_addr_t wh_addr_o,
  output gat_pkg::wh_word_t   wh_din_o,
  output logic                wh_vld_o,
  output gat_pkg::wh_vec_t    wh_vec_o,
  output logic                first_flag_o
);

  localparam int CW = $bits(gat_pkg::col_idx_t);

  gat_pkg::spmm_state_t state;
  gat_pkg::node_addr_t  node_idx;
  gat_pkg::node_addr_t  next_idx;
  gat_pkg::h_addr_t     h_ptr;
  gat_pkg::row_len_t    row_cnt;
  gat_pkg::num_node_t   num_node_q;
  logic                 first_q;
  logic                 take_q;
  logic                 last_node;
  gat_pkg::wh_elem_t    acc [`GAT_FEAT_OUT];
  gat_pkg::data_t       h_val;
  gat_pkg::row_len_t    info_len;
  gat_pkg::num_node_t   info_num;
  logic                 info_first;

  assign {info_len, info_num, info_first} = node_info_i;
  assign h_val        = h_data_i[CW +: `GAT_DATA_W];
  assign wgt.row_addr = h_data_i[CW-1:0];

  assign last_node = (node_idx == gat_pkg::node_addr_t'(`GAT_TOTAL_NODES - 1));
  assign next_idx  = last_node ? '0 : node_idx + 1'b1;

  // Next node's info is requested while the current one is written
  assign node_info_addr_o = (state == gat_pkg::WRITE) ? next_idx : node_idx;
  assign h_data_addr_o    = h_ptr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= gat_pkg::IDLE;
      node_idx   <= '0;
      h_ptr      <= '0;
      row_cnt    <= '0;
      num_node_q <= '0;
      first_q    <= 1'b0;
    end else begin
      case (state)
        gat_pkg::IDLE: begin
          if (start_i && wgt.w_rdy) begin
            h_ptr <= '0;
            state <= gat_pkg::INFO;
          end
        end
        gat_pkg::INFO: begin
          row_cnt    <= info_len;
          num_node_q <= info_num;
          first_q    <= info_first;
          // Hold the next node while the FIFO is nearly full
          if (!afull_i) begin
            state <= (info_len == '0) ? gat_pkg::WRITE : gat_pkg::ROW;
          end
        end
        gat_pkg::ROW: begin
          h_ptr   <= h_ptr + 1'b1;
          row_cnt <= row_cnt - 1'b1;
          if (row_cnt == gat_pkg::row_len_t'(1)) begin
            state <= gat_pkg::DRAIN;
          end
        end
        gat_pkg::DRAIN: begin
          state <= gat_pkg::WRITE;
        end
        gat_pkg::WRITE: begin
          node_idx <= next_idx;
          state    <= last_node ? gat_pkg::IDLE : gat_pkg::INFO;
        end
        default: begin
          state <= gat_pkg::IDLE;
        end
      endcase
    end
  end

  // Entry data lags its address by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      take_q <= 1'b0;
      for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
        acc[k] <= '0;
      end
    end else begin
      take_q <= (state == gat_pkg::ROW);
      for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
        if (state == gat_pkg::WRITE) begin
          acc[k] <= '0;
        end else if (take_q) begin
          acc[k] <= acc[k] + h_val * $signed(wgt.row[k]);
        end
      end
    end
  end

  always_comb begin
    for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
      wh_vec_o[k*`GAT_WH_W +: `GAT_WH_W] = acc[k];
    end
  end

  assign wh_ena_o     = (state == gat_pkg::WRITE);
  assign wh_vld_o     = (state == gat_pkg::WRITE);
  assign wh_addr_o    = node_idx;
  assign wh_din_o     = {wh_vec_o, num_node_q, first_q};
  assign first_flag_o = first_q;

  // A sparse row holds at most one entry per input feature
  a_row_len_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    state == gat_pkg::INFO |-> info_len <= gat_pkg::row_len_t'(`GAT_FEAT_IN)
  ) else $error("node row length exceeds the input feature count");

  // The run's first node opens a subgraph and supplies its source score
  a_first_node_flagged: assert property (
    @(posedge clk) disable iff (!rst_n)
    state == gat_pkg::INFO && node_idx == '0 |-> info_first
  ) else $error("first node of the run is not flagged");

endmodule

//--- hdl/dmvm_unit.sv
`include "gat_cfg.svh"

module dmvm_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start_i,
  gat_wgt_if.dmvm            wgt,
  input  logic               wh_vld_i,
  input  gat_pkg::wh_vec_t   wh_vec_i,
  input  logic               first_flag_i,
  output logic               coef_wr_o,
  output gat_pkg::coef_t     coef_din_o,
  output logic               done_o
);

  localparam int F = `GAT_FEAT_OUT;
  localparam int W = `GAT_WH_W;

  gat_pkg::coef_t     src_sum;
  gat_pkg::coef_t     dst_sum;
  gat_pkg::coef_t     src_q;
  gat_pkg::coef_t     dst_q;
  gat_pkg::coef_t     held_src;
  gat_pkg::coef_t     src_use;
  logic               s1_vld;
  logic               s1_first;
  gat_pkg::num_node_t wr_cnt;

  // Source and destination halves of the attention product
  always_comb begin
    src_sum = '0;
    dst_sum = '0;
    for (int k = 0; k < F; k++) begin
      src_sum += $signed(wgt.a_vec[k]) * $signed(wh_vec_i[k*W +: W]);
      dst_sum += $signed(wgt.a_vec[F+k]) * $signed(wh_vec_i[k*W +: W]);
    end
  end

  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      src_q    <= src_sum;
      dst_q    <= dst_sum;
      s1_first <= first_flag_i;
    end
  end

  // First node of a subgraph supplies the source score for the rest
  assign src_use = s1_first ? src_q : held_src;

  always_ff @(posedge clk) begin
    if (s1_vld) begin
      held_src   <= src_use;
      coef_din_o <= src_use + dst_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld    <= 1'b0;
      coef_wr_o <= 1'b0;
      wr_cnt    <= '0;
    end else begin
      s1_vld    <= wh_vld_i;
      coef_wr_o <= s1_vld;
      // Only a finished run can be restarted
      if (start_i && done_o) begin
        wr_cnt <= '0;
      end else if (coef_wr_o) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
    end
  end

  assign done_o = (wr_cnt == gat_pkg::num_node_t'(`GAT_TOTAL_NODES));

endmodule

//--- hdl/coef_fifo.sv
module coef_fifo #(
  parameter int DATA_W = 32,
  parameter int DEPTH  = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr_i,
  input  logic [DATA_W-1:0] din_i,
  input  logic              rd_i,
  output logic [DATA_W-1:0] dout_o,
  output logic              empty_o,
  output logic              afull_o
);

  localparam int PW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PW-1:0]     wr_ptr;
  logic [PW-1:0]     rd_ptr;
  logic [CW-1:0]     count;
  logic              do_wr;
  logic              do_rd;

  assign do_wr = wr_i && (count != CW'(DEPTH));
  assign do_rd = rd_i && !empty_o;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry shows ahead of the pop
  assign dout_o  = mem[rd_ptr];
  assign empty_o = (count == '0);
  // Leaves room for two writes already in flight
  assign afull_o = (count >= CW'(DEPTH - 2));

  // Back-pressure upstream must keep the writer off a full FIFO
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) wr_i |-> count != CW'(DEPTH)
  ) else $error("coefficient FIFO written while full");

  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n) rd_i |-> !empty_o
  ) else $error("coefficient FIFO read while empty");

endmodule

//--- hdl/gat_feature_top.sv
`include "gat_cfg.svh"

module gat_feature_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  logic                wgt_wr_i,
  input  gat_pkg::wgt_addr_t  wgt_addr_i,
  input  gat_pkg::data_t      wgt_data_i,
  input  logic                wgt_load_done_i,
  output gat_pkg::node_addr_t node_info_addr_o,
  input  gat_pkg::node_info_t node_info_i,
  output gat_pkg::h_addr_t    h_data_addr_o,
  input  gat_pkg::h_entry_t   h_data_i,
  output logic                wh_ena_o,
  output gat_pkg::node_addr_t wh_addr_o,
  output gat_pkg::wh_word_t   wh_din_o,
  output gat_pkg::coef_t      coef_o,
  output logic                coef_empty_o,
  input  logic                coef_rd_i,
  output logic                done_o
);

  gat_wgt_if u_wgt_if ();

  logic             wh_vld;
  gat_pkg::wh_vec_t wh_vec;
  logic             first_flag;
  logic             coef_wr;
  gat_pkg::coef_t   coef_din;
  logic             coef_afull;

  weight_store u_weight_store (
    .clk             (clk),
    .rst_n           (rst_n),
    .wgt_wr_i        (wgt_wr_i),
    .wgt_addr_i      (wgt_addr_i),
    .wgt_data_i      (wgt_data_i),
    .wgt_load_done_i (wgt_load_done_i),
    .wgt             (u_wgt_if.store)
  );

  spmm_engine u_spmm_engine (
    .clk              (clk),
    .rst_n            (rst_n),
    .start_i          (start_i),
    .wgt              (u_wgt_if.spmm),
    .node_info_addr_o (node_info_addr_o),
    .node_info_i      (node_info_i),
    .h_data_addr_o    (h_data_addr_o),
    .h_data_i         (h_data_i),
    .afull_i          (coef_afull),
    .wh_ena_o         (wh_ena_o),
    .wh_addr_o        (wh_addr_o),
    .wh_din_o         (wh_din_o),
    .wh_vld_o         (wh_vld),
    .wh_vec_o         (wh_vec),
    .first_flag_o     (first_flag)
  );

  dmvm_unit u_dmvm_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .wgt          (u_wgt_if.dmvm),
    .wh_vld_i     (wh_vld),
    .wh_vec_i     (wh_vec),
    .first_flag_i (first_flag),
    .coef_wr_o    (coef_wr),
    .coef_din_o   (coef_din),
    .done_o       (done_o)
  );

  coef_fifo #(
    .DATA_W (`GAT_COEF_W),
    .DEPTH  (`GAT_FIFO_DEPTH)
  ) u_coef_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (coef_wr),
    .din_i   (coef_din),
    .rd_i    (coef_rd_i),
    .dout_o  (coef_o),
    .empty_o (coef_empty_o),
    .afull_o (coef_afull)
  );

endmodule

//--- bench/tb_gat_feature.sv
`include "gat_cfg.svh"

module tb_gat_feature;

  localparam int NODES   = `GAT_TOTAL_NODES;
  localparam int FO      = `GAT_FEAT_OUT;
  localparam int CW      = $clog2(`GAT_FEAT_IN);
  localparam int W_NUM   = `GAT_FEAT_IN * FO;
  localparam int A_NUM   = 2 * FO;
  localparam int MAX_LEN = 6;
  localparam int RUNS    = 3;
  localparam int LOAD_CYCLES = W_NUM + A_NUM + 8;
  localparam int WDOG_CYCLES = 16 + LOAD_CYCLES + (MAX_LEN * NODES + 6 * NODES) * RUNS * 4;

  logic                clk;
  logic                rst_n;
  logic                start_i;
  logic                wgt_wr_i;
  gat_pkg::wgt_addr_t  wgt_addr_i;
  gat_pkg::data_t      wgt_data_i;
  logic                wgt_load_done_i;
  gat_pkg::node_addr_t node_info_addr_o;
  gat_pkg::node_info_t node_info_i = '0;
  gat_pkg::h_addr_t    h_data_addr_o;
  gat_pkg::h_entry_t   h_data_i = '0;
  logic                wh_ena_o;
  gat_pkg::node_addr_t wh_addr_o;
  gat_pkg::wh_word_t   wh_din_o;
  gat_pkg::coef_t      coef_o;
  logic                coef_empty_o;
  logic                coef_rd_i = 1'b0;
  logic                done_o;

  int                  w_val [W_NUM];
  int                  a_val [A_NUM];
  int                  row_len [NODES];
  gat_pkg::num_node_t  num_node [NODES];
  logic                first_flag [NODES];
  gat_pkg::node_info_t info_mem [NODES];
  gat_pkg::h_entry_t   h_mem [`GAT_H_DEPTH];
  gat_pkg::wh_word_t   exp_wh [NODES];
  gat_pkg::coef_t      exp_coef [NODES];

  int   wh_cnt = 0;
  int   pop_cnt = 0;
  int   wh_errs = 0;
  int   coef_errs = 0;
  int   ctrl_errs = 0;
  logic reader_en = 1'b0;

  gat_feature_top u_gat_feature_top (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Registered reads of the node-info and sparse-entry memories
  always @(posedge clk) begin
    node_info_i <= info_mem[node_info_addr_o];
    h_data_i    <= h_mem[h_data_addr_o];
  end

  // Pop on alternate cycles so every pop follows a settled empty flag
  always @(posedge clk) begin
    coef_rd_i <= !coef_rd_i && reader_en && !coef_empty_o;
  end

  function automatic int rand_byte();
    return int'($urandom_range(255)) - 128;
  endfunction

  task automatic make_weights();
    for (int j = 0; j < A_NUM; j++) begin
      a_val[j] = rand_byte();
    end
    a_val[0] = 1 + int'($urandom_range(99));
    for (int i = 0; i < W_NUM; i++) begin
      w_val[i] = rand_byte();
    end
    // Column 0 mirrors the source half of a, so its source score follows the entry sign
    for (int k = 0; k < FO; k++) begin
      w_val[k] = a_val[k];
    end
  endtask

  task automatic make_graph(input int run);
    int ptr;
    int size;
    ptr = 0;
    size = 1;
    for (int i = 0; i < `GAT_H_DEPTH; i++) begin
      h_mem[i] = gat_pkg::h_entry_t'(12'h5a3 ^ (i * 97));
    end
    for (int n = 0; n < NODES; n++) begin
      first_flag[n] = (n == 0) || ($urandom_range(3) == 0);
      row_len[n]    = $urandom_range(MAX_LEN);
    end
    if (run == 0) begin
      // Subgraphs {0,1,2} {3,4} {5,6,7}, with empty rows at 2 and 5
      for (int n = 0; n < NODES; n++) begin
        first_flag[n] = (n == 0) || (n == 3) || (n == 5);
      end
      row_len[2] = 0;
      row_len[3] = 1;
      row_len[5] = 0;
    end
    for (int n = 0; n < NODES; n++) begin
      if (first_flag[n]) begin
        size = 1;
        while (n + size < NODES && !first_flag[n + size]) begin
          size++;
        end
      end
      num_node[n] = gat_pkg::num_node_t'(size);
      info_mem[n] = {gat_pkg::row_len_t'(row_len[n]), num_node[n], first_flag[n]};
      for (int e = 0; e < row_len[n]; e++) begin
        if (run == 0 && n == 3) begin
          h_mem[ptr] = {gat_pkg::data_t'(-1 - int'($urandom_range(126))), CW'(0)};
        end else begin
          h_mem[ptr] = {gat_pkg::data_t'(rand_byte()), CW'($urandom_range(`GAT_FEAT_IN - 1))};
        end
        ptr++;
      end
    end
  endtask

  // Expected Wh words and coefficients of all nodes of one run
  function automatic void compute_reference();
    int ptr;
    int held;
    int src;
    int dst;
    int val;
    int col;
    int wh [FO];
    gat_pkg::wh_vec_t vec;
    ptr = 0;
    held = 0;
    for (int n = 0; n < NODES; n++) begin
      for (int k = 0; k < FO; k++) begin
        wh[k] = 0;
      end
      for (int e = 0; e < row_len[n]; e++) begin
        val = int'($signed(h_mem[ptr][CW +: `GAT_DATA_W]));
        col = int'(h_mem[ptr][CW-1:0]);
        for (int k = 0; k < FO; k++) begin
          wh[k] += val * w_val[col * FO + k];
        end
        ptr++;
      end
      src = 0;
      dst = 0;
      for (int k = 0; k < FO; k++) begin
        src += a_val[k] * wh[k];
        dst += a_val[FO + k] * wh[k];
        vec[k*`GAT_WH_W +: `GAT_WH_W] = gat_pkg::wh_elem_t'(wh[k]);
      end
      if (first_flag[n]) begin
        held = src;
      end
      exp_wh[n]   = {vec, num_node[n], first_flag[n]};
      exp_coef[n] = gat_pkg::coef_t'(held + dst);
    end
  endfunction

  always @(negedge clk) begin
    if (start_i) begin
      wh_cnt  = 0;
      pop_cnt = 0;
    end else if (rst_n) begin
      if (done_o) begin
        assert (wh_cnt == NODES) else begin
          ctrl_errs++;
          $display("error at %0t: done_o high after %0d Wh writes", $time, wh_cnt);
        end
        assert (coef_empty_o == (pop_cnt == NODES)) else begin
          ctrl_errs++;
          $display("error at %0t: coef_empty_o is %b after %0d pops", $time, coef_empty_o,
                   pop_cnt);
        end
      end
      if (wh_ena_o) begin
        assert (wh_cnt < NODES && wh_addr_o == gat_pkg::node_addr_t'(wh_cnt)
                && wh_din_o == exp_wh[wh_cnt]) else begin
          wh_errs++;
          $display("error at %0t: Wh write %0d at address %0d is %h, expected %h", $time,
                   wh_cnt, wh_addr_o, wh_din_o, exp_wh[wh_cnt]);
        end
        wh_cnt++;
      end
      if (coef_rd_i) begin
        assert (pop_cnt < NODES && coef_o == exp_coef[pop_cnt]) else begin
          coef_errs++;
          $display("error at %0t: coefficient %0d is %0d, expected %0d", $time, pop_cnt,
                   coef_o, exp_coef[pop_cnt]);
        end
        pop_cnt++;
      end
    end
  end

  initial begin
    void'($urandom(32'h036b1d76));
    rst_n           <= 1'b0;
    start_i         <= 1'b0;
    wgt_wr_i        <= 1'b0;
    wgt_addr_i      <= '0;
    wgt_data_i      <= '0;
    wgt_load_done_i <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (!done_o && !wh_ena_o && coef_empty_o) else begin
      ctrl_errs++;
      $display("error at %0t: outputs not idle after reset", $time);
    end

    make_weights();
    for (int i = 0; i < W_NUM + A_NUM; i++) begin
      @(posedge clk);
      wgt_wr_i   <= 1'b1;
      wgt_addr_i <= gat_pkg::wgt_addr_t'(i);
      wgt_data_i <= gat_pkg::data_t'((i < W_NUM) ? w_val[i] : a_val[i - W_NUM]);
    end
    @(posedge clk);
    wgt_wr_i        <= 1'b0;
    wgt_load_done_i <= 1'b1;
    reader_en       <= 1'b1;
    repeat (2) @(posedge clk);

    for (int run = 0; run < RUNS; run++) begin
      make_graph(run);
      compute_reference();
      @(posedge clk);
      start_i <= 1'b1;
      @(posedge clk);
      start_i <= 0;
      @(negedge clk);
      assert (!done_o) else begin
        ctrl_errs++;
        $display("error at %0t: done_o still high after start", $time);
      end
      // Reader stalls after the first Wh write so the FIFO backs up to afull
      if (run == 1) begin
        while (wh_cnt < 1) begin
          @(posedge clk);
        end
        reader_en <= 1'b0;
        repeat (40) @(posedge clk);
        reader_en <= 1'b1;
      end
      while (!(done_o && pop_cnt == NODES)) begin
        @(posedge clk);
      end
    end

    $display("Errors: %0d in Wh words, %0d in coefficients, %0d in control", wh_errs,
             coef_errs, ctrl_errs);
    if (wh_errs + coef_errs + ctrl_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WDOG_CYCLES * 100);
    $display("Timeout: the run did not finish within %0d clock cycles", WDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+hdl
hdl/gat_pkg.sv
hdl/gat_wgt_if.sv
hdl/weight_store.sv
hdl/spmm_engine.sv
hdl/dmvm_unit.sv
hdl/coef_fifo.sv
hdl/gat_feature_top.sv
bench/tb_gat_feature.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the simulation log
verilator --binary --timing --assert -Wno-fatal --top-module tb_gat_feature \
  -f filelist.f -o sim_gat_feature > build.log 2>&1 &&
./obj_dir/sim_gat_feature > sim.log 2>&1 &&
! grep -q "Simulation failed" sim.log &&
grep -q "Simulation completed successfully" sim.log &&
echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }
